//--- hdl/predecodePkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predecoder package
// bundle geometry, class vector and output slot types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package predecodePkg;

  parameter int ParcelWidth = 16;
  parameter int BundleParcels = 15;
  parameter int BundleWidth = 256;
  parameter int MaxInstrLen = 4; // parcels
  parameter int WindowWidth = 64; // MaxInstrLen parcels

  parameter int DefaultMaxInstr = 12;
  parameter int DefaultMaxJumps = 4;

  typedef logic [3:0] parcelIdxT;

  // end markers of parcels k..k+3, bit 0 is parcel k
  typedef logic [3:0] lenCodeT;

  typedef struct packed {
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic jump;
    logic indir;
    logic fpu;
    logic sys;
  } instrClassT;

  typedef struct packed {
    logic [WindowWidth-1:0] window; // parcels k..k+3, zero past the bundle
    lenCodeT lenCode;
    parcelIdxT offset;
    instrClassT cls;
  } instrSlotT;

  typedef struct packed {
    parcelIdxT offset;
    parcelIdxT ordinal; // position in the instruction list
    instrClassT cls;
  } jumpSlotT;

endpackage

//--- hdl/parcelBoundary.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// parcel boundary finder
// start mask, lookahead codes and start ordinals per parcel
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module parcelBoundary (
  input  logic [predecodePkg::BundleWidth-1:0] bundle,
  input  predecodePkg::parcelIdxT              startOff,
  output logic [predecodePkg::BundleParcels-1:0] startMask,
  output predecodePkg::lenCodeT                lenCodes [predecodePkg::BundleParcels],
  output predecodePkg::parcelIdxT              ordinals [predecodePkg::BundleParcels],
  output logic                                 badStart
);

  localparam int NumParcels = predecodePkg::BundleParcels;
  localparam int MarkerBase = NumParcels * predecodePkg::ParcelWidth;
  localparam int LookAhead = predecodePkg::MaxInstrLen;
  localparam int ExtWidth = NumParcels + LookAhead - 1;

  logic [NumParcels-1:0] endMarks;
  logic [ExtWidth-1:0]   endMarksExt;
  logic [NumParcels-1:0] prevEnd;
  logic [NumParcels-1:0] inRange;

  assign endMarks = bundle[MarkerBase +: NumParcels]; // bit 255 unused

  // markers past the last parcel read as one
  assign endMarksExt = {{(LookAhead - 1){1'b1}}, endMarks};

  // parcel 0 always follows a boundary
  assign prevEnd = {endMarks[NumParcels-2:0], 1'b1};

  always_comb begin
    for (int k = 0; k < NumParcels; k++) begin
      inRange[k] = predecodePkg::parcelIdxT'(k) >= startOff;
    end
  end

  assign startMask = inRange & prevEnd;

  always_comb begin
    for (int k = 0; k < NumParcels; k++) begin
      lenCodes[k] = endMarksExt[k +: LookAhead];
    end
  end

  // running count of starts below each parcel
  always_comb begin
    predecodePkg::parcelIdxT runCount;
    runCount = '0;
    for (int k = 0; k < NumParcels; k++) begin
      ordinals[k] = runCount;
      runCount = runCount + {3'b000, startMask[k]};
    end
  end

  // no parcel can start at 15, so the mask is empty as well
  assign badStart = startOff == 4'd15;

endmodule

//--- hdl/instrClassifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction classifier
// class vector from the first opcode byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module instrClassifier (
  input  logic [7:0]               opcode,
  output predecodePkg::instrClassT cls
);

  logic isBasicRange;
  logic isShiftRange;
  logic isMemRange;
  logic isCondJump;
  logic isLongJump;
  logic isIndirJump;

  assign isBasicRange = opcode <= 8'h27; // 0x00..0x27
  assign isShiftRange = opcode >= 8'h28 && opcode <= 8'h2d;
  assign isMemRange = opcode[7:5] == 3'b010; // 0x40..0x5f

  assign isCondJump = opcode[7:4] == 4'ha;
  assign isLongJump = opcode == 8'hb4 || opcode == 8'hb5;
  assign isIndirJump = opcode == 8'hb6;

  always_comb begin
    cls = '0;

    cls.alu = isBasicRange & ~opcode[2];
    cls.mul = isBasicRange & opcode[2];
    cls.shift = isShiftRange;

    // bit 0 picks direction
    cls.load = isMemRange & ~opcode[0];
    cls.store = isMemRange & opcode[0];

    cls.jump = isCondJump | isLongJump | isIndirJump;
    cls.indir = isIndirJump;

    cls.fpu = opcode == 8'hf0;
    cls.sys = opcode == 8'hff;
  end

endmodule

//--- hdl/slotCompactor.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// slot compactor
// packs selected entries, in order, into output slots
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module slotCompactor #(
  parameter type payloadT = logic [15:0],
  parameter int  NumIn    = 15,
  parameter int  NumOut   = 12
) (
  input  payloadT           entries [NumIn],
  input  logic [NumIn-1:0]  select,
  output payloadT           slots [NumOut],
  output logic [NumOut-1:0] slotEn,
  output logic              overflow
);

  localparam int CntWidth = $clog2(NumIn + 1);

  logic [CntWidth-1:0] rank [NumIn]; // selects below entry i
  logic [CntWidth-1:0] total;

  always_comb begin
    logic [CntWidth-1:0] runCount;
    runCount = '0;
    for (int i = 0; i < NumIn; i++) begin
      rank[i] = runCount;
      runCount = runCount + CntWidth'(select[i]);
    end
    total = runCount;
  end

  // the n-th selected entry lands in slot n
  always_comb begin
    for (int n = 0; n < NumOut; n++) begin
      slots[n] = '0;
      for (int i = n; i < NumIn; i++) begin // rank never exceeds i
        if (select[i] && rank[i] == CntWidth'(n)) begin
          slots[n] = entries[i];
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < NumOut; n++) begin
      slotEn[n] = total > CntWidth'(n);
    end
  end

  assign overflow = total > CntWidth'(NumOut);

endmodule

//--- hdl/predecoderTop.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// instruction predecoder
// finds, classifies and packs one bundle per cycle
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module predecoderTop #(
  parameter int MaxInstr = predecodePkg::DefaultMaxInstr,
  parameter int MaxJumps = predecodePkg::DefaultMaxJumps
) (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                inValid,
  input  logic [predecodePkg::BundleWidth-1:0] bundle,
  input  predecodePkg::parcelIdxT             startOff,
  output logic                                outValid,
  output predecodePkg::instrSlotT             instrSlots [MaxInstr],
  output logic [MaxInstr-1:0]                 instrEn,
  output predecodePkg::jumpSlotT              jumpSlots [MaxJumps],
  output logic [MaxJumps-1:0]                 jumpEn,
  output logic                                hasJumps,
  output logic                                error
);

  localparam int NumParcels = predecodePkg::BundleParcels;
  localparam int PW = predecodePkg::ParcelWidth;
  localparam int ParcelBits = NumParcels * PW;
  localparam int PadBits = predecodePkg::WindowWidth - PW;

  logic [NumParcels-1:0]    startMask;
  predecodePkg::lenCodeT    lenCodes [NumParcels];
  predecodePkg::parcelIdxT  ordinals [NumParcels];
  logic                     badStart;

  logic [ParcelBits+PadBits-1:0] parcelsPadded; // zero parcels past 14
  predecodePkg::instrClassT cls [NumParcels];
  predecodePkg::instrSlotT  instrEntries [NumParcels];
  predecodePkg::jumpSlotT   jumpEntries [NumParcels];
  logic [NumParcels-1:0]    jumpSelect;

  predecodePkg::instrSlotT  instrSlotsNext [MaxInstr];
  logic [MaxInstr-1:0]      instrEnNext;
  logic                     instrOverflow;
  predecodePkg::jumpSlotT   jumpSlotsNext [MaxJumps];
  logic [MaxJumps-1:0]      jumpEnNext;

  parcelBoundary boundary_i (
    .bundle   (bundle),
    .startOff (startOff),
    .startMask(startMask),
    .lenCodes (lenCodes),
    .ordinals (ordinals),
    .badStart (badStart)
  );

  assign parcelsPadded = {{PadBits{1'b0}}, bundle[ParcelBits-1:0]};

  // every parcel is classified as if it were a start
  for (genvar k = 0; k < NumParcels; k++) begin : parcelGen
    instrClassifier classifier_i (
      .opcode(bundle[k*PW +: 8]),
      .cls   (cls[k])
    );

    assign instrEntries[k] = '{
      window:  parcelsPadded[k*PW +: predecodePkg::WindowWidth],
      lenCode: lenCodes[k],
      offset:  predecodePkg::parcelIdxT'(k),
      cls:     cls[k]
    };

    assign jumpEntries[k] = '{
      offset:  predecodePkg::parcelIdxT'(k),
      ordinal: ordinals[k],
      cls:     cls[k]
    };

    assign jumpSelect[k] = startMask[k] & cls[k].jump;
  end

  slotCompactor #(
    .payloadT(predecodePkg::instrSlotT),
    .NumIn   (NumParcels),
    .NumOut  (MaxInstr)
  ) instrCompactor_i (
    .entries (instrEntries),
    .select  (startMask),
    .slots   (instrSlotsNext),
    .slotEn  (instrEnNext),
    .overflow(instrOverflow)
  );

  // extra jumps are simply dropped
  slotCompactor #(
    .payloadT(predecodePkg::jumpSlotT),
    .NumIn   (NumParcels),
    .NumOut  (MaxJumps)
  ) jumpCompactor_i (
    .entries (jumpEntries),
    .select  (jumpSelect),
    .slots   (jumpSlotsNext),
    .slotEn  (jumpEnNext),
    .overflow()
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid   <= 1'b0;
      instrSlots <= '{default: '0};
      instrEn    <= '0;
      jumpSlots  <= '{default: '0};
      jumpEn     <= '0;
      hasJumps   <= 1'b0;
      error      <= 1'b0;
    end else begin
      outValid <= inValid;
      if (inValid) begin // results hold between bundles
        instrSlots <= instrSlotsNext;
        instrEn    <= instrEnNext;
        jumpSlots  <= jumpSlotsNext;
        jumpEn     <= jumpEnNext;
        hasJumps   <= |jumpSelect;
        error      <= badStart | instrOverflow;
      end
    end
  end

endmodule

//--- tests/predecoderModel.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predecoder reference model
// expected outputs per bundle, typed compare tasks
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef PREDECODER_MODEL_SVH
`define PREDECODER_MODEL_SVH

localparam int NumParcels = predecodePkg::BundleParcels;
localparam int MarkerBase = predecodePkg::BundleParcels * predecodePkg::ParcelWidth;
localparam int MaxI = predecodePkg::DefaultMaxInstr;
localparam int MaxJ = predecodePkg::DefaultMaxJumps;

typedef struct packed {
  predecodePkg::instrSlotT [MaxI-1:0] instrSlots;
  logic [MaxI-1:0] instrEn;
  predecodePkg::jumpSlotT [MaxJ-1:0] jumpSlots;
  logic [MaxJ-1:0] jumpEn;
  logic hasJumps;
  logic error;
} expectedT;

// class table, first opcode byte only
function automatic predecodePkg::instrClassT classOf(input logic [7:0] op);
  predecodePkg::instrClassT c;
  c = '0;
  if (op <= 8'h27) begin
    c.mul = op[2];
    c.alu = ~op[2];
  end else if (op >= 8'h28 && op <= 8'h2d) begin
    c.shift = 1'b1;
  end else if (op >= 8'h40 && op <= 8'h5f) begin
    c.store = op[0];
    c.load = ~op[0];
  end else if ((op >= 8'ha0 && op <= 8'haf) || op == 8'hb4 || op == 8'hb5) begin
    c.jump = 1'b1;
  end else if (op == 8'hb6) begin
    c.jump = 1'b1;
    c.indir = 1'b1;
  end else if (op == 8'hf0) begin
    c.fpu = 1'b1;
  end else if (op == 8'hff) begin
    c.sys = 1'b1;
  end
  return c;
endfunction

function automatic expectedT predict(input logic [255:0] b, input predecodePkg::parcelIdxT s);
  expectedT e;
  predecodePkg::instrSlotT slot;
  predecodePkg::jumpSlotT jmp;
  int numStarts;
  int numJumps;
  e = '0;
  numStarts = 0;
  numJumps = 0;
  for (int k = 0; k < NumParcels; k++) begin
    if (k >= int'(s) && (k == 0 || b[MarkerBase + k - 1])) begin
      slot = '0;
      for (int j = 0; j < predecodePkg::MaxInstrLen; j++) begin
        if (k + j < NumParcels) begin
          slot.window[16*j +: 16] = b[16*(k+j) +: 16];
          slot.lenCode[j] = b[MarkerBase + k + j];
        end else begin
          slot.lenCode[j] = 1'b1; // past the bundle
        end
      end
      slot.offset = predecodePkg::parcelIdxT'(k);
      slot.cls = classOf(b[16*k +: 8]);
      if (numStarts < MaxI) begin
        e.instrSlots[numStarts] = slot;
        e.instrEn[numStarts] = 1'b1;
      end
      if (slot.cls.jump) begin
        e.hasJumps = 1'b1;
        if (numJumps < MaxJ) begin
          jmp.offset = slot.offset;
          jmp.ordinal = predecodePkg::parcelIdxT'(numStarts);
          jmp.cls = slot.cls;
          e.jumpSlots[numJumps] = jmp;
          e.jumpEn[numJumps] = 1'b1;
        end
        numJumps++;
      end
      numStarts++;
    end
  end
  e.error = (numStarts > MaxI) || (s == 4'd15);
  return e;
endfunction

task automatic compareInstrSlot(input string testName, input int idx,
                                input predecodePkg::instrSlotT expected,
                                input predecodePkg::instrSlotT actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: instrSlots[%0d] expected %h, actual %h",
             testName, idx, expected, actual);
    $display("Simulation failed");
    $fatal(1, "instruction slot mismatch");
  end
endtask

task automatic compareJumpSlot(input string testName, input int idx,
                               input predecodePkg::jumpSlotT expected,
                               input predecodePkg::jumpSlotT actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: jumpSlots[%0d] expected %h, actual %h",
             testName, idx, expected, actual);
    $display("Simulation failed");
    $fatal(1, "jump slot mismatch");
  end
endtask

// jumpEn is zero extended to the instruction width
task automatic compareEn(input string testName, input string what,
                         input logic [MaxI-1:0] expected, input logic [MaxI-1:0] actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: %s expected %h, actual %h", testName, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "enable mismatch");
  end
endtask

task automatic compareFlag(input string testName, input string what,
                           input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("[ERROR] %s: %s expected %b, actual %b", testName, what, expected, actual);
    $display("Simulation failed");
    $fatal(1, "flag mismatch");
  end
endtask

`endif

//--- tests/predecoderTb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// predecoder testbench
// directed and back-to-back random bundles vs the model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

module predecoderTb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ClkPeriod = 40;
  localparam int NumRandom = 200;
  localparam int NumBundles = NumRandom + 5;

  logic clk;
  logic reset;
  logic inValid;
  logic [predecodePkg::BundleWidth-1:0] bundle;
  predecodePkg::parcelIdxT startOff;
  logic outValid;
  predecodePkg::instrSlotT instrSlots [predecodePkg::DefaultMaxInstr];
  logic [predecodePkg::DefaultMaxInstr-1:0] instrEn;
  predecodePkg::jumpSlotT jumpSlots [predecodePkg::DefaultMaxJumps];
  logic [predecodePkg::DefaultMaxJumps-1:0] jumpEn;
  logic hasJumps;
  logic error;

  integer seed = 32'hcec3_d8d3;

  `include "predecoderModel.svh"

  predecoderTop predecoderTop_i (
    .clk       (clk),
    .reset     (reset),
    .inValid   (inValid),
    .bundle    (bundle),
    .startOff  (startOff),
    .outValid  (outValid),
    .instrSlots(instrSlots),
    .instrEn   (instrEn),
    .jumpSlots (jumpSlots),
    .jumpEn    (jumpEn),
    .hasJumps  (hasJumps),
    .error     (error)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  initial begin
    #((NumBundles + 20) * ClkPeriod);
    $display("Watchdog: the run timed out before all tests finished");
    $display("Simulation failed");
    $fatal(1, "timeout");
  end

  function automatic logic [255:0] randomBundle();
    logic [255:0] b;
    for (int w = 0; w < 8; w++) begin
      b[32*w +: 32] = $random(seed);
    end
    return b;
  endfunction

  task automatic checkOutputs(input string testName, input logic [255:0] b,
                              input predecodePkg::parcelIdxT s);
    expectedT e;
    e = predict(b, s);
    compareFlag(testName, "outValid", 1'b1, outValid);
    for (int i = 0; i < MaxI; i++) begin
      compareInstrSlot(testName, i, e.instrSlots[i], instrSlots[i]);
    end
    compareEn(testName, "instrEn", e.instrEn, instrEn);
    for (int i = 0; i < MaxJ; i++) begin
      compareJumpSlot(testName, i, e.jumpSlots[i], jumpSlots[i]);
    end
    compareEn(testName, "jumpEn", MaxI'(e.jumpEn), MaxI'(jumpEn));
    compareFlag(testName, "hasJumps", e.hasJumps, hasJumps);
    compareFlag(testName, "error", e.error, error);
  endtask

  // one bundle in, results sampled at the negedge after capture
  task automatic applyAndCheck(input string testName, input logic [255:0] b,
                               input predecodePkg::parcelIdxT s);
    @(posedge clk);
    inValid <= 1'b1;
    bundle <= b;
    startOff <= s;
    @(posedge clk);
    inValid <= 1'b0;
    @(negedge clk);
    checkOutputs(testName, b, s);
  endtask

  task automatic resetValues();
    @(posedge clk);
    @(negedge clk);
    compareFlag("resetState", "outValid", 1'b0, outValid);
    compareEn("resetState", "instrEn", '0, instrEn);
    compareEn("resetState", "jumpEn", '0, MaxI'(jumpEn));
    compareFlag("resetState", "hasJumps", 1'b0, hasJumps);
    compareFlag("resetState", "error", 1'b0, error);
  endtask

  // every class lands in the first 12 parcels, spare jumps in the tail
  task automatic oneParcelBundle();
    logic [7:0] ops [15] = '{8'h00, 8'h04, 8'h27, 8'h28, 8'h40, 8'h5f, 8'ha0, 8'hb4,
                            8'hb6, 8'hf0, 8'hff, 8'h30, 8'h2d, 8'haf, 8'hb5};
    logic [255:0] b;
    b = randomBundle();
    for (int k = 0; k < NumParcels; k++) begin
      b[16*k +: 8] = ops[k];
    end
    b[MarkerBase +: 15] = '1; // every parcel ends an instruction
    applyAndCheck("oneParcel", b, 4'd0);
    compareEn("oneParcel", "instrEn", 12'hfff, instrEn);
    compareFlag("oneParcel", "error", 1'b1, error);
  endtask

  task automatic mixedLengthBundle();
    logic [255:0] b;
    b = randomBundle();
    b[MarkerBase +: 15] = 15'h5a26; // lengths 2,1,3,4,2,1,2
    applyAndCheck("mixedLengths", b, 4'd3);
    compareEn("mixedLengths", "instrEn", 12'h01f, instrEn); // starts 3,6,10,12,13
    applyAndCheck("mixedLengthsMid", b, 4'd7);
    compareEn("mixedLengthsMid", "instrEn", 12'h007, instrEn);
  endtask

  task automatic jumpPacking();
    logic [7:0] startOps [8] = '{8'ha3, 8'h00, 8'hb6, 8'hb4, 8'ha9, 8'h40, 8'hb5, 8'haf};
    logic [255:0] b;
    b = randomBundle();
    for (int k = 0; k < NumParcels; k++) begin
      b[16*k +: 8] = (k % 2 == 0) ? startOps[k/2] : 8'ha5; // odd parcels are tails
    end
    b[MarkerBase +: 15] = 15'h6aaa;
    applyAndCheck("jumpPacking", b, 4'd0);
    compareEn("jumpPacking", "jumpEn", 12'h00f, MaxI'(jumpEn));
    compareFlag("jumpPacking", "indir", 1'b1, jumpSlots[1].cls.indir);
    compareFlag("jumpPacking", "hasJumps", 1'b1, hasJumps);
    compareFlag("jumpPacking", "error", 1'b0, error);
  endtask

  task automatic backToBackRandom();
    logic [255:0] b;
    logic [255:0] prevB;
    predecodePkg::parcelIdxT s;
    predecodePkg::parcelIdxT prevS;
    b = '0;
    s = '0;
    for (int i = 0; i <= NumRandom; i++) begin
      prevB = b;
      prevS = s;
      @(posedge clk);
      if (i < NumRandom) begin
        b = randomBundle();
        s = predecodePkg::parcelIdxT'({$random(seed)} % 15);
        inValid <= 1'b1;
        bundle <= b;
        startOff <= s;
      end else begin
        inValid <= 1'b0;
      end
      if (i > 0) begin
        @(negedge clk);
        checkOutputs("backToBack", prevB, prevS); // previous bundle now held
      end
    end
  endtask

  task automatic lastStartOffset();
    logic [255:0] b;
    b = randomBundle();
    applyAndCheck("badStart", b, 4'd15);
    compareFlag("badStart", "error", 1'b1, error);
    compareEn("badStart", "instrEn", '0, instrEn);
  endtask

  initial begin
    reset = 1'b1;
    inValid = 1'b0;
    bundle = '0;
    startOff = '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    resetValues();
    oneParcelBundle();
    mixedLengthBundle();
    jumpPacking();
    backToBackRandom();
    lastStartOffset();

    $display("Simulation passed");
    $finish;
  end

endmodule

//--- predecoder.f
+incdir+tests
hdl/predecodePkg.sv
hdl/parcelBoundary.sv
hdl/instrClassifier.sv
hdl/slotCompactor.sv
hdl/predecoderTop.sv
tests/predecoderTb.sv

//--- run.sh
#!/usr/bin/env bash
# compile and run the predecoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
  -f predecoder.f --top-module predecoderTb -o predecoderSim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

output=$(./obj_dir/predecoderSim 2>&1)
status=$?
echo "$output"

if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
